//--- logic/ex_adder_if.sv
// Shared adder bus between the multiply/divide unit and the ALU.
// The multiply/divide side supplies operands, the ALU returns the sums.

`timescale 1ns/1ps
`default_nettype none

interface ex_adder_if;

  // High while the multiply/divide unit owns the adder
  logic                         multdiv_sel;
  logic [ex_cfg_pkg::XLEN:0]    operand_a;
  logic [ex_cfg_pkg::XLEN:0]    operand_b;
  logic [ex_cfg_pkg::XLEN-1:0]  adder_result;
  // Full sum with carry out in the top bit
  logic [ex_cfg_pkg::XLEN+1:0]  adder_result_ext;
  logic                         is_equal;

  modport md_mp (
    output multdiv_sel, operand_a, operand_b,
    input  adder_result, adder_result_ext, is_equal
  );

  modport alu_mp (
    input  multdiv_sel, operand_a, operand_b,
    output adder_result, adder_result_ext, is_equal
  );

endinterface

`default_nettype wire

//--- logic/ex_alu.sv
// Combinational integer ALU for the execute stage.
// Its 33-bit adder is lent to the multiply/divide unit through the adder bus.

`timescale 1ns/1ps
`default_nettype none

module ex_alu (
  input  ex_op_pkg::alu_op_e            operator_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   operand_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   operand_b_i,
  ex_adder_if.alu_mp                    adder,
  output logic [ex_cfg_pkg::XLEN-1:0]   result_o,
  output logic                          comparison_result_o,
  output logic [ex_cfg_pkg::XLEN-1:0]   adder_result_o
);

  localparam int unsigned W = ex_cfg_pkg::XLEN;

  logic         negate;
  logic         is_signed;
  logic [W:0]   add_a;
  logic [W:0]   add_b;
  logic         add_cin;
  logic [W+1:0] sum_ext;
  logic         is_equal;
  logic         is_less;
  logic [4:0]   shamt;
  logic [W-1:0] shift_result;

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  // Subtract for SUB and for every compare
  always_comb begin
    unique case (operator_i)
      ex_op_pkg::ALU_ADD,
      ex_op_pkg::ALU_XOR,
      ex_op_pkg::ALU_OR,
      ex_op_pkg::ALU_AND,
      ex_op_pkg::ALU_SLL,
      ex_op_pkg::ALU_SRL,
      ex_op_pkg::ALU_SRA: negate = 1'b0;
      default:            negate = 1'b1;
    endcase
  end

  assign is_signed = (operator_i == ex_op_pkg::ALU_LT) ||
                     (operator_i == ex_op_pkg::ALU_GE) ||
                     (operator_i == ex_op_pkg::ALU_SLT);

  // One extra top bit so bit W of the difference is the compare sign
  always_comb begin
    if (adder.multdiv_sel) begin
      add_a   = adder.operand_a;
      add_b   = adder.operand_b;
      add_cin = 1'b0;
    end else begin
      add_a   = {is_signed & operand_a_i[W-1], operand_a_i};
      add_b   = {is_signed & operand_b_i[W-1], operand_b_i} ^ {(W+1){negate}};
      add_cin = negate;
    end
  end

  assign sum_ext = {1'b0, add_a} + {1'b0, add_b} + {{(W+1){1'b0}}, add_cin};

  assign adder.adder_result     = sum_ext[W-1:0];
  assign adder.adder_result_ext = sum_ext;
  assign adder.is_equal         = is_equal;
  assign adder_result_o         = sum_ext[W-1:0];

  ////////////////////////////////////////////////////////////
  // Compare
  ////////////////////////////////////////////////////////////

  assign is_equal = (sum_ext[W:0] == '0);
  assign is_less  = sum_ext[W];

  always_comb begin
    unique case (operator_i)
      ex_op_pkg::ALU_LT,
      ex_op_pkg::ALU_LTU,
      ex_op_pkg::ALU_SLT,
      ex_op_pkg::ALU_SLTU: comparison_result_o = is_less;
      ex_op_pkg::ALU_GE,
      ex_op_pkg::ALU_GEU:  comparison_result_o = ~is_less;
      ex_op_pkg::ALU_EQ:   comparison_result_o = is_equal;
      ex_op_pkg::ALU_NE:   comparison_result_o = ~is_equal;
      default:             comparison_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign shamt = operand_b_i[4:0];

  always_comb begin
    unique case (operator_i)
      ex_op_pkg::ALU_SLL: shift_result = operand_a_i << shamt;
      ex_op_pkg::ALU_SRA: shift_result = W'($signed(operand_a_i) >>> shamt);
      default:            shift_result = operand_a_i >> shamt;
    endcase
  end

  // Result select
  always_comb begin
    unique case (operator_i)
      ex_op_pkg::ALU_ADD,
      ex_op_pkg::ALU_SUB:  result_o = sum_ext[W-1:0];
      ex_op_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ex_op_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      ex_op_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      ex_op_pkg::ALU_SLL,
      ex_op_pkg::ALU_SRL,
      ex_op_pkg::ALU_SRA:  result_o = shift_result;
      ex_op_pkg::ALU_SLT,
      ex_op_pkg::ALU_SLTU: result_o = {{(W-1){1'b0}}, is_less};
      default:             result_o = '0;
    endcase
  end

  // Only checked once the shared adder has left reset
  always_comb begin
    if (adder.multdiv_sel === 1'b0) begin
      assert final (!$isunknown(operator_i))
        else $error("ALU operator is unknown");
    end
  end

endmodule

`default_nettype wire

//--- logic/ex_block.sv
// Execute stage top level.
// Holds the ALU, the iterative multiply/divide unit and the branch-target adder,
// and selects the write-back value and the jump target.

`timescale 1ns/1ps
`default_nettype none

module ex_block (
  input  logic                               clk_i,
  input  logic                               rst_n_i,

  // ALU
  input  ex_op_pkg::alu_op_e                 alu_operator_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]        alu_operand_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]        alu_operand_b_i,

  // Branch target
  input  ex_op_pkg::jt_mux_sel_e             jt_mux_sel_i,
  input  logic [ex_cfg_pkg::BT_IMM_W-1:0]    bt_operand_imm_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]        pc_id_i,

  // Multiply / divide
  input  ex_op_pkg::md_op_e                  multdiv_operator_i,
  input  logic                               mult_en_i,
  input  logic                               div_en_i,
  input  logic [1:0]                         multdiv_signed_mode_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]        multdiv_operand_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]        multdiv_operand_b_i,

  output logic [ex_cfg_pkg::XLEN-1:0]        alu_adder_result_ex_o,
  output logic [ex_cfg_pkg::XLEN-1:0]        regfile_wdata_o,
  output logic [ex_cfg_pkg::XLEN-1:0]        jump_target_o,
  output logic                               branch_decision_o,
  output logic                               ex_valid_o
);

  localparam int unsigned W = ex_cfg_pkg::XLEN;

  logic [W-1:0] alu_result;
  logic [W-1:0] multdiv_result;
  logic         multdiv_valid;
  logic         multdiv_en;

  ex_adder_if adder_bus ();

  ex_alu i_alu (
    .operator_i          (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .adder               (adder_bus),
    .result_o            (alu_result),
    .comparison_result_o (branch_decision_o),
    .adder_result_o      (alu_adder_result_ex_o)
  );

  ex_multdiv_slow i_multdiv (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mult_en_i     (mult_en_i),
    .div_en_i      (div_en_i),
    .operator_i    (multdiv_operator_i),
    .signed_mode_i (multdiv_signed_mode_i),
    .op_a_i        (multdiv_operand_a_i),
    .op_b_i        (multdiv_operand_b_i),
    .adder         (adder_bus),
    .valid_o       (multdiv_valid),
    .result_o      (multdiv_result)
  );

  // Without the M extension the multiply/divide result is never selected
  if (ex_cfg_pkg::RV32M) begin : g_multdiv_en
    assign multdiv_en = mult_en_i | div_en_i;
  end else begin : g_no_multdiv
    assign multdiv_en = 1'b0;
  end

  assign regfile_wdata_o = multdiv_en ? multdiv_result : alu_result;
  assign ex_valid_o      = multdiv_en ? multdiv_valid : 1'b1;

  // Target = pc + sign-extended immediate times two
  if (ex_cfg_pkg::BRANCH_TARGET_ALU) begin : g_bt_alu
    logic [W-1:0] bt_result;

    assign bt_result = pc_id_i +
      {{(W-ex_cfg_pkg::BT_IMM_W-1){bt_operand_imm_i[ex_cfg_pkg::BT_IMM_W-1]}},
       bt_operand_imm_i, 1'b0};
    assign jump_target_o = (jt_mux_sel_i == ex_op_pkg::JT_ALU) ? alu_adder_result_ex_o
                                                                : bt_result;
  end else begin : g_no_bt_alu
    assign jump_target_o = alu_adder_result_ex_o;
  end

endmodule

`default_nettype wire

//--- logic/ex_cfg_pkg.sv
// Widths and build options of the execute stage.
// Change the options here to trim the multiply/divide unit or the target adder.

`default_nettype none

package ex_cfg_pkg;

  // Data path width
  localparam int unsigned XLEN = 32;

  // Branch immediate width before the implicit shift by one
  localparam int unsigned BT_IMM_W = 12;

  // M extension present
  localparam bit RV32M = 1'b1;

  // Separate adder for branch targets
  localparam bit BRANCH_TARGET_ALU = 1'b1;

  // Iteration counter, wide enough for 32 steps
  localparam int unsigned MD_CNT_W = 6;

endpackage

`default_nettype wire

//--- logic/ex_multdiv_slow.sv
// Iterative multiply/divide unit, one bit per cycle.
// Every add and subtract goes through the ALU adder on the shared adder bus.
// Enables are levels held by the issuer until valid_o pulses.

`timescale 1ns/1ps
`default_nettype none

module ex_multdiv_slow (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          mult_en_i,
  input  logic                          div_en_i,
  input  ex_op_pkg::md_op_e             operator_i,
  input  logic [1:0]                    signed_mode_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   op_a_i,
  input  logic [ex_cfg_pkg::XLEN-1:0]   op_b_i,
  ex_adder_if.md_mp                     adder,
  output logic                          valid_o,
  output logic [ex_cfg_pkg::XLEN-1:0]   result_o
);

  localparam int unsigned W = ex_cfg_pkg::XLEN;
  localparam logic [ex_cfg_pkg::MD_CNT_W-1:0] LAST_STEP = ex_cfg_pkg::MD_CNT_W'(W - 1);

  typedef enum logic [2:0] {
    MD_IDLE, MD_ABS_A, MD_ABS_B, MD_MULT, MD_DIV, MD_FIX, MD_FINISH
  } md_state_e;

  md_state_e                     state_q;
  logic [ex_cfg_pkg::MD_CNT_W-1:0] cnt_q;
  // Accumulator, holds the remainder during divide
  logic [W:0]                    acc_q;
  // Multiplier bits, product low word, dividend and quotient
  logic [W-1:0]                  mq_q;
  // Multiplicand or divisor magnitude
  logic [W:0]                    opa_q;
  logic                          a_neg_q;
  logic                          q_neg_q;
  logic                          div_zero_q;

  logic                          a_neg;
  logic                          b_neg;
  logic                          mult_sub;
  logic [W:0]                    rem_sh;
  logic [W:0]                    trial;
  logic [W+1:0]                  sum_signed;
  logic [W+1:0]                  mult_step;
  logic [W-1:0]                  fix_val;
  logic                          fix_neg;

  assign a_neg = signed_mode_i[0] & op_a_i[W-1];
  assign b_neg = signed_mode_i[1] & op_b_i[W-1];

  // Last multiply step subtracts when b is signed
  assign mult_sub = (cnt_q == LAST_STEP) & signed_mode_i[1] & mq_q[0];
  assign rem_sh   = {acc_q[W-1:0], mq_q[W-1]};

  assign fix_val = (operator_i == ex_op_pkg::MD_OP_REM) ? acc_q[W-1:0] : mq_q;
  assign fix_neg = (operator_i == ex_op_pkg::MD_OP_REM) ? a_neg_q : (q_neg_q & ~div_zero_q);

  ////////////////////////////////////////////////////////////
  // Shared adder operands
  ////////////////////////////////////////////////////////////

  // Subtraction as ~(~x + y) since the borrowed adder has no carry in
  always_comb begin
    unique case (state_q)
      MD_IDLE: begin
        // Sum is zero only for a zero divisor
        adder.operand_a = '0;
        adder.operand_b = {1'b0, op_b_i};
      end
      MD_ABS_A: begin
        adder.operand_a = '1;
        adder.operand_b = {1'b0, op_a_i};
      end
      MD_ABS_B: begin
        adder.operand_a = '1;
        adder.operand_b = {1'b0, op_b_i};
      end
      MD_MULT: begin
        adder.operand_a = mult_sub ? ~acc_q : acc_q;
        adder.operand_b = mq_q[0] ? opa_q : '0;
      end
      MD_DIV: begin
        adder.operand_a = ~rem_sh;
        adder.operand_b = opa_q;
      end
      MD_FIX: begin
        adder.operand_a = '1;
        adder.operand_b = {1'b0, fix_val};
      end
      default: begin
        adder.operand_a = '0;
        adder.operand_b = '0;
      end
    endcase
  end

  assign adder.multdiv_sel = (state_q != MD_IDLE) | div_en_i;

  // Signed 34-bit view of the unsigned sum of two 33-bit operands
  assign sum_signed = {adder.adder_result_ext[W+1] ^ adder.operand_a[W] ^ adder.operand_b[W],
                       adder.adder_result_ext[W:0]};
  assign mult_step  = mult_sub ? ~sum_signed : sum_signed;
  assign trial      = ~adder.adder_result_ext[W:0];

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        MD_IDLE: begin
          cnt_q <= '0;
          if (mult_en_i) begin
            state_q <= MD_MULT;
          end else if (div_en_i) begin
            state_q <= MD_ABS_A;
          end
        end
        MD_ABS_A: state_q <= MD_ABS_B;
        MD_ABS_B: state_q <= MD_DIV;
        MD_MULT,
        MD_DIV: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == LAST_STEP) begin
            state_q <= (state_q == MD_MULT) ? MD_FINISH : MD_FIX;
          end
        end
        MD_FIX:  state_q <= MD_FINISH;
        default: state_q <= MD_IDLE;
      endcase
    end
  end

  // Data path registers
  always_ff @(posedge clk_i) begin
    unique case (state_q)
      MD_IDLE: begin
        acc_q      <= '0;
        mq_q       <= op_b_i;
        opa_q      <= {a_neg, op_a_i};
        a_neg_q    <= a_neg;
        q_neg_q    <= a_neg ^ b_neg;
        div_zero_q <= adder.is_equal;
      end
      MD_ABS_A: mq_q <= a_neg_q ? ~adder.adder_result : op_a_i;
      MD_ABS_B: opa_q <= {1'b0, b_neg ? ~adder.adder_result : op_b_i};
      MD_MULT: begin
        acc_q <= mult_step[W+1:1];
        mq_q  <= {mult_step[0], mq_q[W-1:1]};
      end
      MD_DIV: begin
        // Restore when the trial difference goes negative
        if (!trial[W]) begin
          acc_q <= trial;
          mq_q  <= {mq_q[W-2:0], 1'b1};
        end else begin
          acc_q <= rem_sh;
          mq_q  <= {mq_q[W-2:0], 1'b0};
        end
      end
      MD_FIX: mq_q <= fix_neg ? ~adder.adder_result : fix_val;
      default: ;
    endcase
  end

  assign valid_o  = (state_q == MD_FINISH);
  assign result_o = (operator_i == ex_op_pkg::MD_OP_MULH) ? acc_q[W-1:0] : mq_q;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  a_one_enable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mult_en_i && div_en_i));

  a_op_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q != MD_IDLE) |-> $stable(operator_i));

  a_valid_after_run: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(valid_o) |-> $past(mult_en_i || div_en_i));

endmodule

`default_nettype wire

//--- logic/ex_op_pkg.sv
// Operation encodings shared by the execute stage.
// Decode drives these onto the ALU, multiply/divide and jump-target select inputs.

`default_nettype none

package ex_op_pkg;

  ////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////

  typedef enum logic [4:0] {
    // Arithmetic and logic
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    // Shifts, amount from operand b[4:0]
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    // Branch compares, result on comparison_result_o
    ALU_LT,
    ALU_LTU,
    ALU_GE,
    ALU_GEU,
    ALU_EQ,
    ALU_NE,
    // Set-less-than, result written back as 0 or 1
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  ////////////////////////////////////////////////////////////
  // Multiply / divide operations
  ////////////////////////////////////////////////////////////

  // Signedness comes separately from signed_mode: bit 0 for a, bit 1 for b
  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // Jump target source
  typedef enum logic {
    JT_ALU,
    JT_BT_ALU
  } jt_mux_sel_e;

endpackage

`default_nettype wire

//--- sim.f
logic/ex_cfg_pkg.sv
logic/ex_op_pkg.sv
logic/ex_adder_if.sv
logic/ex_alu.sv
logic/ex_multdiv_slow.sv
logic/ex_block.sv
tb/tb_ex_block.sv

//--- tb/tb_ex_block.sv
// Self-checking testbench for the execute stage.
// Random and directed ALU, branch, jump and multiply/divide cases are checked
// against a reference model of the RV32IM rules.

`timescale 1ns/1ps
`default_nettype none

module tb_ex_block;

  localparam int CLK_PERIOD  = 20;
  localparam int ALU_RAND    = 300;
  localparam int JT_RAND     = 40;
  localparam int MD_RAND     = 150;
  localparam int MD_MAX_CYC  = 40;
  // Cycle budget of the whole run
  localparam int ALU_CYC     = ALU_RAND + JT_RAND + 6 + 6 * 25;
  localparam int MD_OPS      = MD_RAND + 8 * 25 + 4 * 25;
  localparam int TIMEOUT_CYC = 8 + ALU_CYC + MD_OPS * (MD_MAX_CYC + 2) + 200;

  typedef struct packed {
    logic [4:0]  alu_op;
    logic [31:0] a;
    logic [31:0] b;
    logic        jt_sel;
    logic [11:0] imm;
    logic [31:0] pc;
    logic        mult_en;
    logic        div_en;
    logic [1:0]  md_op;
    logic [1:0]  mode;
    logic [31:0] md_a;
    logic [31:0] md_b;
  } stim_t;

  typedef struct packed {
    logic [31:0] wdata;
    logic [31:0] adder;
    logic [31:0] target;
    logic        is_br;
    logic        branch;
  } exp_t;

  logic                    clk;
  logic                    rst_n;
  ex_op_pkg::alu_op_e      alu_operator;
  logic [31:0]             alu_operand_a;
  logic [31:0]             alu_operand_b;
  ex_op_pkg::jt_mux_sel_e  jt_mux_sel;
  logic [11:0]             bt_operand_imm;
  logic [31:0]             pc_id;
  ex_op_pkg::md_op_e       multdiv_operator;
  logic                    mult_en;
  logic                    div_en;
  logic [1:0]              multdiv_signed_mode;
  logic [31:0]             multdiv_operand_a;
  logic [31:0]             multdiv_operand_b;
  logic [31:0]             alu_adder_result_ex_o;
  logic [31:0]             regfile_wdata_o;
  logic [31:0]             jump_target_o;
  logic                    branch_decision_o;
  logic                    ex_valid_o;

  // Stimulus currently on the DUT inputs
  stim_t applied;
  logic  check_en;

  ex_block i_dut (
    .clk_i                 (clk),
    .rst_n_i               (rst_n),
    .alu_operator_i        (alu_operator),
    .alu_operand_a_i       (alu_operand_a),
    .alu_operand_b_i       (alu_operand_b),
    .jt_mux_sel_i          (jt_mux_sel),
    .bt_operand_imm_i      (bt_operand_imm),
    .pc_id_i               (pc_id),
    .multdiv_operator_i    (multdiv_operator),
    .mult_en_i             (mult_en),
    .div_en_i              (div_en),
    .multdiv_signed_mode_i (multdiv_signed_mode),
    .multdiv_operand_a_i   (multdiv_operand_a),
    .multdiv_operand_b_i   (multdiv_operand_b),
    .alu_adder_result_ex_o (alu_adder_result_ex_o),
    .regfile_wdata_o       (regfile_wdata_o),
    .jump_target_o         (jump_target_o),
    .branch_decision_o     (branch_decision_o),
    .ex_valid_o            (ex_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic exp_t ref_ex(input stim_t s);
    exp_t        e;
    logic        lt_s;
    logic        lt_u;
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    logic        div_s;
    logic [31:0] quot;
    logic [31:0] rem;

    e    = '0;
    lt_s = $signed(s.a) < $signed(s.b);
    lt_u = s.a < s.b;
    case (s.alu_op)
      ex_op_pkg::ALU_ADD:  e.wdata = s.a + s.b;
      ex_op_pkg::ALU_SUB:  e.wdata = s.a - s.b;
      ex_op_pkg::ALU_XOR:  e.wdata = s.a ^ s.b;
      ex_op_pkg::ALU_OR:   e.wdata = s.a | s.b;
      ex_op_pkg::ALU_AND:  e.wdata = s.a & s.b;
      ex_op_pkg::ALU_SLL:  e.wdata = s.a << s.b[4:0];
      ex_op_pkg::ALU_SRL:  e.wdata = s.a >> s.b[4:0];
      ex_op_pkg::ALU_SRA:  e.wdata = $signed(s.a) >>> s.b[4:0];
      ex_op_pkg::ALU_SLT:  e.wdata = {31'b0, lt_s};
      ex_op_pkg::ALU_SLTU: e.wdata = {31'b0, lt_u};
      default:             e.is_br = 1'b1;
    endcase
    case (s.alu_op)
      ex_op_pkg::ALU_LT:  e.branch = lt_s;
      ex_op_pkg::ALU_LTU: e.branch = lt_u;
      ex_op_pkg::ALU_GE:  e.branch = !lt_s;
      ex_op_pkg::ALU_GEU: e.branch = !lt_u;
      ex_op_pkg::ALU_EQ:  e.branch = (s.a == s.b);
      ex_op_pkg::ALU_NE:  e.branch = (s.a != s.b);
      default:            e.branch = 1'b0;
    endcase
    // Subtract and every compare run a - b through the adder
    if (s.alu_op == ex_op_pkg::ALU_SUB || s.alu_op == ex_op_pkg::ALU_SLT ||
        s.alu_op == ex_op_pkg::ALU_SLTU || e.is_br) begin
      e.adder = s.a - s.b;
    end else begin
      e.adder = s.a + s.b;
    end
    e.target = (s.jt_sel == ex_op_pkg::JT_BT_ALU) ?
               s.pc + {{19{s.imm[11]}}, s.imm, 1'b0} : e.adder;

    if (s.mult_en || s.div_en) begin
      ext_a = s.mode[0] ? {{32{s.md_a[31]}}, s.md_a} : {32'b0, s.md_a};
      ext_b = s.mode[1] ? {{32{s.md_b[31]}}, s.md_b} : {32'b0, s.md_b};
      prod  = ext_a * ext_b;
      div_s = (s.mode == 2'b11);
      if (s.md_b == 32'b0) begin
        quot = '1;
        rem  = s.md_a;
      end else if (div_s && s.md_a == 32'h8000_0000 && s.md_b == '1) begin
        quot = s.md_a;
        rem  = '0;
      end else if (div_s) begin
        quot = $signed(s.md_a) / $signed(s.md_b);
        rem  = $signed(s.md_a) % $signed(s.md_b);
      end else begin
        quot = s.md_a / s.md_b;
        rem  = s.md_a % s.md_b;
      end
      case (s.md_op)
        ex_op_pkg::MD_OP_MULL: e.wdata = prod[31:0];
        ex_op_pkg::MD_OP_MULH: e.wdata = prod[63:32];
        ex_op_pkg::MD_OP_DIV:  e.wdata = quot;
        default:               e.wdata = rem;
      endcase
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("CHECK FAILED at %0d ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    abort_run();
  endtask

  task automatic show_error(input string msg);
    $display("ERROR at %0d ns: %s", $time, msg);
    abort_run();
  endtask

  function automatic logic [31:0] edge_val(input int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  // Mostly random, sometimes a sign boundary value
  function automatic logic [31:0] pick_word();
    if ($urandom % 4 == 0) begin
      return edge_val($urandom % 5);
    end
    return $urandom;
  endfunction

  // Inputs change only on the falling edge
  task automatic apply(input stim_t s);
    alu_operator        <= ex_op_pkg::alu_op_e'(s.alu_op);
    alu_operand_a       <= s.a;
    alu_operand_b       <= s.b;
    jt_mux_sel          <= ex_op_pkg::jt_mux_sel_e'(s.jt_sel);
    bt_operand_imm      <= s.imm;
    pc_id               <= s.pc;
    multdiv_operator    <= ex_op_pkg::md_op_e'(s.md_op);
    mult_en             <= s.mult_en;
    div_en              <= s.div_en;
    multdiv_signed_mode <= s.mode;
    multdiv_operand_a   <= s.md_a;
    multdiv_operand_b   <= s.md_b;
    applied             <= s;
  endtask

  // Keeps the multiply/divide operator of the last operation
  function automatic stim_t alu_stim(input logic [4:0] op, input logic [31:0] a,
                                     input logic [31:0] b);
    stim_t s;

    s         = applied;
    s.alu_op  = op;
    s.a       = a;
    s.b       = b;
    s.jt_sel  = 1'($urandom % 2);
    s.imm     = 12'($urandom);
    s.pc      = $urandom;
    s.mult_en = 1'b0;
    s.div_en  = 1'b0;
    return s;
  endfunction

  task automatic run_alu(input stim_t s);
    @(negedge clk);
    apply(s);
  endtask

  task automatic run_md(input logic [1:0] op, input logic [1:0] mode,
                        input logic [31:0] a, input logic [31:0] b);
    stim_t s;
    int    cyc;

    s         = alu_stim(5'($urandom % 16), $urandom, $urandom);
    s.md_op   = op;
    s.mode    = mode;
    s.md_a    = a;
    s.md_b    = b;
    s.mult_en = (op == ex_op_pkg::MD_OP_MULL) || (op == ex_op_pkg::MD_OP_MULH);
    s.div_en  = !s.mult_en;
    cyc       = 0;
    @(negedge clk);
    apply(s);
    do begin
      @(negedge clk);
      cyc = cyc + 1;
    end while (ex_valid_o !== 1'b1 && cyc < MD_MAX_CYC);
    assert (ex_valid_o === 1'b1)
      else show_error("multiply/divide result never became valid");
    // Drop the enable right after the valid pulse
    s.mult_en = 1'b0;
    s.div_en  = 1'b0;
    apply(s);
  endtask

  ////////////////////////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////////////////////////

  initial begin : compare_outputs
    exp_t e;

    forever begin
      @(negedge clk);
      if (check_en) begin
        e = ref_ex(applied);
        if (applied.mult_en || applied.div_en) begin
          if (ex_valid_o === 1'b1) begin
            assert (regfile_wdata_o === e.wdata)
              else show_mismatch("regfile_wdata_o", regfile_wdata_o, e.wdata);
          end
        end else begin
          assert (ex_valid_o === 1'b1)
            else show_mismatch("ex_valid_o", {31'b0, ex_valid_o}, 32'd1);
          if (e.is_br) begin
            assert (branch_decision_o === e.branch)
              else show_mismatch("branch_decision_o", {31'b0, branch_decision_o},
                                 {31'b0, e.branch});
          end else begin
            assert (regfile_wdata_o === e.wdata)
              else show_mismatch("regfile_wdata_o", regfile_wdata_o, e.wdata);
          end
          assert (alu_adder_result_ex_o === e.adder)
            else show_mismatch("alu_adder_result_ex_o", alu_adder_result_ex_o, e.adder);
          assert (jump_target_o === e.target)
            else show_mismatch("jump_target_o", jump_target_o, e.target);
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_CYC * CLK_PERIOD);
    show_error("run hung, watchdog expired before all operations finished");
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin : drive_stimulus
    logic [1:0] op_r;
    logic [1:0] mode_r;

    void'($urandom(14994));
    rst_n    = 1'b0;
    check_en = 1'b0;
    applied  = '0;
    apply('0);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (ex_valid_o === 1'b1)
      else show_mismatch("ex_valid_o", {31'b0, ex_valid_o}, 32'd1);
    check_en <= 1'b1;

    repeat (ALU_RAND) run_alu(alu_stim(5'($urandom % 16), pick_word(), pick_word()));
    // SLL, SRL and SRA by 0 and by 31
    for (int k = 0; k < 3; k++) begin
      run_alu(alu_stim(5'(ex_op_pkg::ALU_SLL) + 5'(k), pick_word(), {27'($urandom), 5'd0}));
      run_alu(alu_stim(5'(ex_op_pkg::ALU_SLL) + 5'(k), pick_word(), {27'($urandom), 5'd31}));
    end
    // Six branch compares, LT through NE
    for (int k = 0; k < 6; k++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          run_alu(alu_stim(5'(ex_op_pkg::ALU_LT) + 5'(k), edge_val(i), edge_val(j)));
        end
      end
    end
    repeat (JT_RAND) run_alu(alu_stim(5'(ex_op_pkg::ALU_ADD), $urandom, $urandom));

    // Boundary operands, every mode for multiply, signed and unsigned for divide
    for (int op = 0; op < 4; op++) begin
      for (int m = 0; m < 4; m++) begin
        if (op < 2 || m == 0 || m == 3) begin
          for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
              run_md(2'(op), 2'(m), edge_val(i), edge_val(j));
            end
          end
        end
      end
    end
    repeat (MD_RAND) begin
      op_r   = 2'($urandom % 4);
      mode_r = (op_r < 2) ? 2'($urandom % 4) : (($urandom % 2) ? 2'b11 : 2'b00);
      run_md(op_r, mode_r, pick_word(), pick_word());
    end

    repeat (2) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
